// File: build.f
+incdir+hw
hw/decodePkg.sv
hw/streamIf.sv
hw/instrDecoder.sv
hw/bundleFifo.sv
hw/operandFetch.sv
hw/decodeStage.sv
testbench/decode_checker.sv
testbench/decodeStage_tb.sv

// File: hw/bundleFifo.sv
`include "decode_params.svh"

module bundleFifo #(
    parameter type payload_t = logic,
    parameter int  depth = `FIFO_DEPTH
) (
    input logic     clk,
    input logic     rst,
    streamIf.sink   inBus,
    streamIf.source outBus
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    payload_t        mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            fresh;   // Entry written on the last edge, not yet visible
    logic            wrEn;
    logic            rdEn;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A full FIFO still takes a write when its head leaves the same cycle
    assign outBus.valid = count > cntW'(fresh);
    assign outBus.data = mem[rdPtr];
    assign inBus.ready = !rst && (count < cntW'(depth) || (outBus.valid && outBus.ready));
    assign wrEn = inBus.valid && inBus.ready;
    assign rdEn = outBus.valid && outBus.ready;

    always_ff @(posedge clk) begin
        if (wrEn)
            mem[wrPtr] <= inBus.data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            fresh <= 1'b0;
        end else begin
            fresh <= wrEn;
            if (wrEn)
                wrPtr <= nextPtr(wrPtr);
            if (rdEn)
                rdPtr <= nextPtr(rdPtr);
            count <= count + cntW'(wrEn) - cntW'(rdEn); // Occupancy
        end
    end

endmodule

// File: hw/decodePkg.sv
`include "decode_params.svh"

package decodePkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`IDX_W-1:0] regIdx_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_NEG = 4'd4,
        ALU_NOT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRA = 4'd8,
        ALU_SLT = 4'd9,
        ALU_CMP = 4'd10,
        ALU_NOP = 4'd15
    } aluOp_e;

    // Second ALU operand source
    typedef enum logic [1:0] {
        B_RY   = 2'd0,
        B_IMM  = 2'd1,
        B_ZERO = 2'd2
    } bSel_e;

    typedef enum logic [1:0] {
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2,
        MEM_NONE  = 2'd3
    } memCtrl_e;

    typedef enum logic [1:0] {
        BR_B    = 2'd0,
        BR_JR   = 2'd1,
        BR_BEQZ = 2'd2,
        BR_BNEZ = 2'd3 // Also used when there is no branch
    } branchKind_e;

    typedef struct packed {
        aluOp_e      aluOp;
        bSel_e       controlB;
        memCtrl_e    controlMem;
        logic        ifJump;     // Active low
        word_t       immNum;
        branchKind_e jorB;
        logic        memToReg;   // 0 selects memory data
        regIdx_t     readReg1;
        regIdx_t     readReg2;
        regIdx_t     writeReg;
    } decodeCtrl_t;

    typedef struct packed {
        decodeCtrl_t ctrl;
        word_t       readData1;
        word_t       readData2;
    } operandBundle_t;

endpackage

// File: hw/decodeStage.sv
module decodeStage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instrValid,
    output logic                    instrReady,
    input  decodePkg::word_t        instr,
    input  decodePkg::regIdx_t      wbReg,
    input  decodePkg::word_t        wbData,
    output logic                    outValid,
    input  logic                    outReady,
    output decodePkg::aluOp_e       aluOp,
    output decodePkg::bSel_e        controlB,
    output decodePkg::memCtrl_e     controlMem,
    output logic                    ifJump,
    output decodePkg::word_t        immNum,
    output decodePkg::branchKind_e  jorB,
    output logic                    memToReg,
    output decodePkg::regIdx_t      writeReg,
    output decodePkg::word_t        readData1,
    output decodePkg::word_t        readData2
);
    import decodePkg::*;

    operandBundle_t outBundle;

    streamIf #(.payload_t(decodeCtrl_t)) decBus (.clk(clk));
    streamIf #(.payload_t(decodeCtrl_t)) fifoBus (.clk(clk));

    instrDecoder dec0 (
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .decOut     (decBus.source)
    );

    bundleFifo #(.payload_t(decodeCtrl_t)) fifo0 (
        .clk    (clk),
        .rst    (rst),
        .inBus  (decBus.sink),
        .outBus (fifoBus.source)
    );

    operandFetch fetch0 (
        .clk       (clk),
        .rst       (rst),
        .inBus     (fifoBus.sink),
        .wbReg     (wbReg),
        .wbData    (wbData),
        .outValid  (outValid),
        .outReady  (outReady),
        .outBundle (outBundle)
    );

    // Flatten the output bundle
    assign aluOp = outBundle.ctrl.aluOp;
    assign controlB = outBundle.ctrl.controlB;
    assign controlMem = outBundle.ctrl.controlMem;
    assign ifJump = outBundle.ctrl.ifJump;
    assign immNum = outBundle.ctrl.immNum;
    assign jorB = outBundle.ctrl.jorB;
    assign memToReg = outBundle.ctrl.memToReg;
    assign writeReg = outBundle.ctrl.writeReg;
    assign readData1 = outBundle.readData1;
    assign readData2 = outBundle.readData2;

endmodule

// File: hw/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Datapath widths
`define DATA_W 16
`define IDX_W 4

// Register file
`define REG_COUNT 16
`define ZERO_REG 15 // Reads as zero, writes dropped

// Special registers
`define SP_REG 8
`define T_REG 9
`define IH_REG 10

// Bundle FIFO
`define FIFO_DEPTH 4

`endif

// File: hw/instrDecoder.sv
`include "decode_params.svh"

module instrDecoder (
    input  logic             instrValid,
    output logic             instrReady,
    input  decodePkg::word_t instr,
    streamIf.source          decOut
);
    import decodePkg::*;

    logic [4:0]  op5;
    logic [7:0]  op8;
    logic [4:0]  fn5;
    logic [1:0]  fn2;
    regIdx_t     rx;
    regIdx_t     ry;
    regIdx_t     rz;
    logic        isRegOp;  // 11101 group, function in low bits
    logic        isAddSub; // ADDU / SUBU
    logic        isShift;
    logic        isJr;
    logic        isBteqz;
    logic        isAddSp;
    decodeCtrl_t ctrl;

    assign op5 = instr[15:11];
    assign op8 = instr[15:8];
    assign fn5 = instr[4:0];
    assign fn2 = instr[1:0];
    assign rx = {1'b0, instr[10:8]};
    assign ry = {1'b0, instr[7:5]};
    assign rz = {1'b0, instr[4:2]};

    assign isRegOp = (op5 == 5'b11101);
    assign isAddSub = (op5 == 5'b11100);
    assign isShift = (op5 == 5'b00110);
    assign isJr = isRegOp && (instr[7:0] == 8'h00);
    assign isBteqz = (op8 == 8'b01100000);
    assign isAddSp = (op8 == 8'b01100011);

    ////////////////////////////////////////
    // Handshake passes straight through
    ////////////////////////////////////////
    assign decOut.valid = instrValid;
    assign decOut.data = ctrl;
    assign instrReady = decOut.ready;

    ////////////////////////////////////////
    // Decode table
    ////////////////////////////////////////
    always_comb begin
        // First read port
        if (isAddSp || op5 == 5'b10010 || op5 == 5'b11010)
            ctrl.readReg1 = regIdx_t'(`SP_REG);
        else if (isBteqz)
            ctrl.readReg1 = regIdx_t'(`T_REG);
        else if (op5 == 5'b11110 && fn5 == 5'b00000) // MFIH
            ctrl.readReg1 = regIdx_t'(`IH_REG);
        else if (op8 == 8'b01100100 || isShift || op5 == 5'b01111)
            ctrl.readReg1 = ry;
        else if (isRegOp && (fn5 == 5'b01111 || fn5 == 5'b01011))
            ctrl.readReg1 = ry;
        else if (op5 == 5'b00001 || op5 == 5'b00010 || op5 == 5'b01101
                || (isRegOp && instr[7:0] == 8'b01000000))
            ctrl.readReg1 = regIdx_t'(`ZERO_REG);
        else
            ctrl.readReg1 = rx;

        // Second read port
        if (op5 == 5'b11010)
            ctrl.readReg2 = rx; // Store data for SW_SP
        else if (op5 == 5'b11011 || isAddSub || (isRegOp && (fn5 == 5'b00010
                || fn5 == 5'b01101 || fn5 == 5'b01010 || fn5 == 5'b01100)))
            ctrl.readReg2 = ry;
        else
            ctrl.readReg2 = regIdx_t'(`ZERO_REG);

        // ALU operation
        if (op5 == 5'b00100 || op5 == 5'b00101 || isBteqz || (isAddSub && fn2 == 2'b11))
            ctrl.aluOp = ALU_SUB;
        else if (isRegOp && fn5 == 5'b01100)
            ctrl.aluOp = ALU_AND;
        else if (isRegOp && fn5 == 5'b01011)
            ctrl.aluOp = ALU_NEG;
        else if (isRegOp && fn5 == 5'b01111)
            ctrl.aluOp = ALU_NOT;
        else if (isRegOp && fn5 == 5'b01101)
            ctrl.aluOp = ALU_OR;
        else if (isShift && fn2 == 2'b00)
            ctrl.aluOp = ALU_SLL;
        else if (isShift && fn2 == 2'b11)
            ctrl.aluOp = ALU_SRA;
        else if (op5 == 5'b01011 || (isRegOp && fn5 == 5'b00010))
            ctrl.aluOp = ALU_SLT;
        else if (isRegOp && fn5 == 5'b01010)
            ctrl.aluOp = ALU_CMP;
        else
            ctrl.aluOp = ALU_ADD;

        // B operand
        if ((isAddSub && (fn2 == 2'b01 || fn2 == 2'b11))
                || (isRegOp && (fn5 == 5'b01100 || fn5 == 5'b01010 || fn5 == 5'b01011
                || fn5 == 5'b01101 || fn5 == 5'b00010))
                || (op5 == 5'b01111 && fn5 == 5'b00000))
            ctrl.controlB = B_RY;
        else if ((isShift && (fn2 == 2'b00 || fn2 == 2'b11)) || op5 == 5'b01000
                || op5 == 5'b01001 || op5 == 5'b01011 || isAddSp || op5 == 5'b01101
                || op5 == 5'b10010 || op5 == 5'b10011 || op5 == 5'b11010 || op5 == 5'b11011)
            ctrl.controlB = B_IMM;
        else
            ctrl.controlB = B_ZERO;

        if (op5 == 5'b10010 || op5 == 5'b10011)
            ctrl.controlMem = MEM_READ;
        else if (op5 == 5'b11010 || op5 == 5'b11011)
            ctrl.controlMem = MEM_WRITE;
        else
            ctrl.controlMem = MEM_NONE;

        // Low for B, BEQZ, BNEZ, the 01100 group and JR
        ctrl.ifJump = !(op5 == 5'b00010 || op5 == 5'b00100 || op5 == 5'b00101
                        || op5 == 5'b01100 || isJr);

        // Immediate extension
        if (op5 == 5'b01001 || isAddSp || op5 == 5'b00100 || op5 == 5'b00101
                || isBteqz || op5 == 5'b10010 || op5 == 5'b11010)
            ctrl.immNum = {{8{instr[7]}}, instr[7:0]};
        else if (op5 == 5'b01000 && !instr[4])
            ctrl.immNum = {{12{instr[3]}}, instr[3:0]};
        else if (op5 == 5'b00010)
            ctrl.immNum = {{5{instr[10]}}, instr[10:0]};
        else if (op5 == 5'b10011 || op5 == 5'b11011)
            ctrl.immNum = {{11{instr[4]}}, instr[4:0]};
        else if (isShift)
            ctrl.immNum = (instr[4:2] == 3'b000) ? word_t'(8) : {13'b0, instr[4:2]};
        else if (op5 == 5'b01101 || op5 == 5'b01011)
            ctrl.immNum = {8'h00, instr[7:0]};
        else
            ctrl.immNum = '0;

        if (op5 == 5'b00010)
            ctrl.jorB = BR_B;
        else if (isJr)
            ctrl.jorB = BR_JR;
        else if (op5 == 5'b00100 || isBteqz)
            ctrl.jorB = BR_BEQZ;
        else
            ctrl.jorB = BR_BNEZ;

        ctrl.memToReg = !(op5 == 5'b10010 || op5 == 5'b10011); // Loads take memory data

        // Destination register
        if (isAddSp || op8 == 8'b01100100)
            ctrl.writeReg = regIdx_t'(`SP_REG);
        else if ((isRegOp && (fn5 == 5'b01010 || fn5 == 5'b00010)) || op5 == 5'b01011)
            ctrl.writeReg = regIdx_t'(`T_REG);
        else if (op5 == 5'b11110 && fn5 == 5'b00001) // MTIH
            ctrl.writeReg = regIdx_t'(`IH_REG);
        else if (isAddSub && (fn2 == 2'b01 || fn2 == 2'b11))
            ctrl.writeReg = rz;
        else if (op5 == 5'b10011 || op5 == 5'b01000)
            ctrl.writeReg = ry;
        else if (op5 == 5'b00010 || op5 == 5'b00100 || op5 == 5'b00101 || isBteqz
                || isJr || instr == '0 || op5 == 5'b11011 || op5 == 5'b11010)
            ctrl.writeReg = regIdx_t'(`ZERO_REG); // No result to write
        else
            ctrl.writeReg = rx;
    end

endmodule

// File: hw/operandFetch.sv
`include "decode_params.svh"

module operandFetch (
    input  logic                       clk,
    input  logic                       rst,
    streamIf.sink                      inBus,
    input  decodePkg::regIdx_t         wbReg,
    input  decodePkg::word_t           wbData,
    output logic                       outValid,
    input  logic                       outReady,
    output decodePkg::operandBundle_t  outBundle
);
    import decodePkg::*;

    word_t       regFile [`REG_COUNT];
    decodeCtrl_t ctrl;
    word_t       rdData1;
    word_t       rdData2;
    logic        take;

    assign ctrl = inBus.data;

    // Read ports, index 15 always gives zero
    assign rdData1 = (ctrl.readReg1 == regIdx_t'(`ZERO_REG)) ? '0 : regFile[ctrl.readReg1];
    assign rdData2 = (ctrl.readReg2 == regIdx_t'(`ZERO_REG)) ? '0 : regFile[ctrl.readReg2];

    assign inBus.ready = outReady || !outValid; // Slot free or draining
    assign take = inBus.valid && inBus.ready;

    ////////////////////////////////////////
    // Register file and write-back
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regFile[i] <= '0;
        end else if (wbReg != regIdx_t'(`ZERO_REG)) begin
            regFile[wbReg] <= wbData;
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst)
            outValid <= 1'b0;
        else if (take)
            outValid <= 1'b1;
        else if (outReady)
            outValid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            outBundle.ctrl <= ctrl;
            outBundle.readData1 <= rdData1;
            outBundle.readData2 <= rdData2;
        end
    end

endmodule

// File: hw/streamIf.sv
interface streamIf #(
    parameter type payload_t = logic
) (
    input logic clk
);

    logic     valid;
    logic     ready;
    payload_t data;

    // Producer side
    modport source (
        input  clk,
        output valid,
        output data,
        input  ready
    );

    // Consumer side
    modport sink (
        input  clk,
        input  valid,
        input  data,
        output ready
    );

endinterface

// File: testbench/decodeStage_tb.sv
`include "decode_params.svh"

module decodeStage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import decodePkg::*;

    logic        clk;
    logic        rst;
    logic        instrValid;
    logic        instrReady;
    word_t       instr;
    regIdx_t     wbReg;
    word_t       wbData;
    logic        outValid;
    logic        outReady;
    aluOp_e      aluOp;
    bSel_e       controlB;
    memCtrl_e    controlMem;
    logic        ifJump;
    word_t       immNum;
    branchKind_e jorB;
    logic        memToReg;
    regIdx_t     writeReg;
    word_t       readData1;
    word_t       readData2;

    decodeCtrl_t ctrlQ[$];   // Expected bundles in order
    word_t       data1Q[$];
    word_t       data2Q[$];
    word_t       instrQ[$];
    int          sent = 0;
    int          received = 0;
    int          mismatches = 0;
    int          otherErrs = 0;
    int          lineCount = 0;
    logic [31:0] lcgState = 32'haf142a3c;

    decodeStage dut0 (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .outValid   (outValid),
        .outReady   (outReady),
        .aluOp      (aluOp),
        .controlB   (controlB),
        .controlMem (controlMem),
        .ifJump     (ifJump),
        .immNum     (immNum),
        .jorB       (jorB),
        .memToReg   (memToReg),
        .writeReg   (writeReg),
        .readData1  (readData1),
        .readData2  (readData2)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkCtrl(input string name, input decodeCtrl_t exp, input decodeCtrl_t act);
        if (act !== exp) begin
            $display("MISMATCH %s ctrl: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic pushInstr(input word_t v);
        @(negedge clk);
        instrValid = 1'b1;
        instr = v;
        @(posedge clk);
        while (!instrReady)
            @(posedge clk);
        sent++;
    endtask

    // Only once the output has drained, so no bundle reads a changing register
    task automatic writeBack(input regIdx_t r, input word_t d);
        @(negedge clk);
        instrValid = 1'b0;
        while (sent != received)
            @(negedge clk);
        wbReg = r;
        wbData = d;
        @(negedge clk);
        wbReg = regIdx_t'(`ZERO_REG);
    endtask

    // About one stall cycle in three
    always @(negedge clk) begin
        lcgState = nextRand(lcgState);
        outReady = (lcgState[31:16] % 3) != 0;
    end

    ////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////
    always @(posedge clk) begin
        decodeCtrl_t act;
        string       name;
        if (!rst && outValid && outReady) begin
            if (ctrlQ.size() == 0) begin
                $display("ERROR: a bundle was delivered when none was expected");
                otherErrs++;
            end else begin
                act = '0;
                act.aluOp = aluOp;
                act.controlB = controlB;
                act.controlMem = controlMem;
                act.ifJump = ifJump;
                act.immNum = immNum;
                act.jorB = jorB;
                act.memToReg = memToReg;
                act.writeReg = writeReg;
                name = $sformatf("bundle %0d instr %h", received, instrQ.pop_front());
                checkCtrl(name, ctrlQ.pop_front(), act);
                checkWord({name, " readData1"}, data1Q.pop_front(), readData1);
                checkWord({name, " readData2"}, data2Q.pop_front(), readData2);
            end
            received++;
        end
    end

    initial begin : watchdog
        wait (lineCount > 0);
        repeat (lineCount * 40 + 100) @(posedge clk);
        $display("ERROR: run timed out with %0d bundles outstanding", sent - received);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus from file
    ////////////////////////////////////////
    initial begin
        int          fd;
        int          c;
        logic [7:0]  kind;
        logic [15:0] iw, a, b, m, j, imm, jb, mr, wr, d1, d2;
        decodeCtrl_t want;
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        wbReg = regIdx_t'(`ZERO_REG);
        wbData = '0;
        outReady = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd = $fopen("testbench/decode_stim.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open testbench/decode_stim.txt");
            $display("Test failed");
            $finish;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == 10)
                    lineCount++;
                c = $fgetc(fd);
            end
            $fclose(fd);
            fd = $fopen("testbench/decode_stim.txt", "r");
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind == "#") begin
                    c = 0;
                    while (c != 10 && c != -1)
                        c = $fgetc(fd); // Skip comment line
                end else if (kind == "W") begin
                    void'($fscanf(fd, "%h %h", wr, d1));
                    writeBack(regIdx_t'(wr[3:0]), d1);
                end else begin
                    void'($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                                  iw, a, b, m, j, imm, jb, mr, wr, d1, d2));
                    want = '0;
                    want.aluOp = aluOp_e'(a[3:0]);
                    want.controlB = bSel_e'(b[1:0]);
                    want.controlMem = memCtrl_e'(m[1:0]);
                    want.ifJump = j[0];
                    want.immNum = imm;
                    want.jorB = branchKind_e'(jb[1:0]);
                    want.memToReg = mr[0];
                    want.writeReg = regIdx_t'(wr[3:0]);
                    ctrlQ.push_back(want);
                    data1Q.push_back(d1);
                    data2Q.push_back(d2);
                    instrQ.push_back(iw);
                    pushInstr(iw);
                end
            end
            $fclose(fd);
            @(negedge clk);
            instrValid = 1'b0;
            while (received != sent)
                @(negedge clk);
            repeat (4) @(negedge clk);
            if (ctrlQ.size() != 0) begin
                $display("ERROR: %0d expected bundles never arrived", ctrlQ.size());
                otherErrs++;
            end
            $display("Summary: %0d mismatches, %0d other errors, %0d assertion failures",
                     mismatches, otherErrs, dut0.chk0.assertFails);
            if (mismatches == 0 && otherErrs == 0 && dut0.chk0.assertFails == 0)
                $display("Test passed");
            else
                $display("Test failed");
            $finish;
        end
    end

endmodule

// File: testbench/decode_checker.sv
module decodeChecker (
    input logic        clk,
    input logic        rst,
    input logic        instrReady,
    input logic        outValid,
    input logic        outReady,
    input logic [63:0] outs       // All output fields side by side
);
    timeunit 1ns;
    timeprecision 1ps;

    int assertFails = 0;

    ////////////////////////////////////////
    // Output held while stalled
    ////////////////////////////////////////
    holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outs)))
        else begin
            $error("output changed while outValid high and outReady low");
            assertFails++;
        end

    // No instruction taken in reset
    readyLowInReset: assert property (@(posedge clk) rst |-> !instrReady)
        else begin
            $error("instrReady high during reset");
            assertFails++;
        end

    validLowAfterReset: assert property (@(posedge clk) rst |=> !outValid)
        else begin
            $error("outValid high on the cycle after reset");
            assertFails++;
        end

endmodule

bind decodeStage decodeChecker chk0 (
    .clk        (clk),
    .rst        (rst),
    .instrReady (instrReady),
    .outValid   (outValid),
    .outReady   (outReady),
    .outs       ({aluOp, controlB, controlMem, ifJump, immNum, jorB, memToReg,
                  writeReg, readData1, readData2})
);

// File: testbench/decode_stim.txt
# W reg data : one write-back, all hex
# I instr aluOp controlB controlMem ifJump imm jorB memToReg writeReg data1 data2 : all hex
I e14d 0 0 3 1 0000 3 1 3 0000 0000
W f 1234
I 6d80 0 1 3 1 0080 3 1 5 0000 0000
W 1 0011
W 2 0022
W 3 0033
W 4 8004
W 8 0800
W 9 0009
I e14d 0 0 3 1 0000 3 1 3 0011 0022
I e38b 1 0 3 1 0000 3 1 2 0033 8004
I e94c 2 0 3 1 0000 3 1 1 0011 0022
I ec6d 3 0 3 1 0000 3 1 4 8004 0033
I ea2a a 0 3 1 0000 3 1 9 0022 0011
I eb82 9 0 3 1 0000 3 1 9 0033 8004
I e98b 4 0 3 1 0000 3 1 1 8004 0000
I ea6f 5 2 3 1 0000 3 1 2 0033 0000
I 4bf0 0 1 3 1 fff0 3 1 3 0033 0000
I 414a 0 1 3 1 fffa 3 1 2 0011 0000
I 6305 0 1 3 0 0005 3 1 8 0800 0000
I 5a90 9 1 3 1 0090 3 1 9 0022 0000
I 3180 6 1 3 1 0008 3 1 1 8004 0000
I 326f 8 1 3 1 0003 3 1 2 0033 0000
I 9953 0 1 1 1 fff3 3 0 2 0011 0000
I 9304 0 1 1 1 0004 3 0 3 0800 0000
I dc22 0 1 2 1 0002 3 1 f 8004 0011
I d2fe 0 1 2 1 fffe 3 1 f 0800 0022
I 17f0 0 2 3 0 fff0 0 1 f 0000 0000
I 2110 1 2 3 0 0010 2 1 f 0011 0000
I 2c80 1 2 3 0 ff80 3 1 f 8004 0000
I 6003 1 2 3 0 0003 2 1 f 0009 0000
I eb00 0 2 3 0 0000 1 1 f 0033 0000
